// File: common/game_config.svh
`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

// board shape
`define GAME_DIM      4
`define GAME_EXP_W    4
`define GAME_WIN_EXP  11

// board placement on screen, in pixels
`define CELL_X0     380
`define CELL_Y0     180
`define CELL_SIZE   21
`define CELL_PITCH  25
`define COORD_W     10

// colours as 4 bits each of red, green, blue
`define COLOR_BLANK   12'h000
`define COLOR_BG      12'hFFF
`define COLOR_EMPTY   12'h666
`define COLOR_TILE1   12'hEDC
`define COLOR_TILE2   12'hC98
`define COLOR_TILE3   12'hD95
`define COLOR_TILE4   12'hF84
`define COLOR_TILE5   12'hF65
`define COLOR_TILE6   12'hF33
`define COLOR_TILE7   12'hEB4
`define COLOR_TILE8   12'hFB0
`define COLOR_TILE9   12'h8B5
`define COLOR_TILE10  12'h4AD
`define COLOR_TILE11  12'h15D

`endif

// File: common/game_pkg.sv
`include "game_config.svh"

package game_pkg;

    // tile exponent, 0 is an empty cell and k stands for 2^k
    typedef logic [`GAME_EXP_W-1:0] tile_t;

    // index 0 is the leading end of a line
    typedef tile_t [`GAME_DIM-1:0] line_t;

    // board[row][col], row 0 at the top, col 0 at the left
    typedef line_t [`GAME_DIM-1:0] board_t;

    typedef enum logic [1:0] {
        DIR_UP,
        DIR_DOWN,
        DIR_LEFT,
        DIR_RIGHT
    } dir_t;

    // value of a freshly placed tile
    localparam tile_t TILE_NEW = tile_t'(1);

    // one new tile in the top-left cell
    localparam board_t BOARD_INIT = board_t'(TILE_NEW);

endpackage

// File: common/video_pkg.sv
`include "game_config.svh"

package video_pkg;

    // scan position from the video timing block
    typedef logic [`COORD_W-1:0] coord_t;

    // 4 bits per channel
    typedef logic [11:0] rgb_t;

endpackage

// File: common/move_if.sv
`timescale 1ns/1ps

interface moveIf;
    import game_pkg::*;

    // request side, valid/ready
    logic   reqValid;
    logic   reqReady;
    dir_t   dir;
    board_t board;

    // single-cycle result pulse
    logic   rspValid;
    board_t rspBoard;

    modport ctrl (
        output reqValid,
        output dir,
        output board,
        input  reqReady,
        input  rspValid,
        input  rspBoard
    );

    modport shift (
        input  reqValid,
        input  dir,
        input  board,
        output reqReady,
        output rspValid,
        output rspBoard
    );

endinterface

// File: game/line_merge.sv
`timescale 1ns/1ps
`include "game_config.svh"

module line_merge (
    input  game_pkg::line_t lineIn,
    output game_pkg::line_t lineOut
);
    import game_pkg::*;

    // extra zero slot so the last tile has a neighbour to compare
    tile_t [`GAME_DIM:0] work;
    int                  cnt;
    int                  k;
    logic                skip;

    always_comb begin
        // slide non-empty tiles to the front, order kept
        work = '0;
        cnt  = 0;
        for (int i = 0; i < `GAME_DIM; i++) begin
            if (lineIn[i] != '0) begin
                work[cnt] = lineIn[i];
                cnt++;
            end
        end

        // pairwise merge from the front, a merged tile is not reused
        lineOut = '0;
        k       = 0;
        skip    = 1'b0;
        for (int i = 0; i < `GAME_DIM; i++) begin
            if (skip) begin
                skip = 1'b0;
            end else if (work[i] != '0) begin
                if (work[i] == work[i+1]) begin
                    lineOut[k] = work[i] + tile_t'(1);
                    skip       = 1'b1;
                end else begin
                    lineOut[k] = work[i];
                end
                k++;
            end
        end
    end

endmodule

// File: game/board_shifter.sv
`timescale 1ns/1ps
`include "game_config.svh"

module board_shifter (
    input  logic Clk,
    input  logic Reset,
    moveIf.shift mv
);
    import game_pkg::*;

    logic   pending;
    dir_t   holdDir;
    board_t holdBoard;
    board_t lines;
    board_t merged;
    board_t shifted;

    assign mv.reqReady = !pending && !mv.rspValid;

    // lines start at the edge the tiles move toward
    always_comb begin
        for (int l = 0; l < `GAME_DIM; l++) begin
            for (int p = 0; p < `GAME_DIM; p++) begin
                case (holdDir)
                    DIR_UP:   lines[l][p] = holdBoard[p][l];
                    DIR_DOWN: lines[l][p] = holdBoard[`GAME_DIM-1-p][l];
                    DIR_LEFT: lines[l][p] = holdBoard[l][p];
                    default:  lines[l][p] = holdBoard[l][`GAME_DIM-1-p];
                endcase
            end
        end
    end

    for (genvar g = 0; g < `GAME_DIM; g++) begin : gLine
        line_merge merge0 (
            .lineIn  (lines[g]),
            .lineOut (merged[g])
        );
    end

    // back to row/col order
    always_comb begin
        for (int l = 0; l < `GAME_DIM; l++) begin
            for (int p = 0; p < `GAME_DIM; p++) begin
                case (holdDir)
                    DIR_UP:   shifted[p][l] = merged[l][p];
                    DIR_DOWN: shifted[`GAME_DIM-1-p][l] = merged[l][p];
                    DIR_LEFT: shifted[l][p] = merged[l][p];
                    default:  shifted[l][`GAME_DIM-1-p] = merged[l][p];
                endcase
            end
        end
    end

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            pending     <= 1'b0;
            mv.rspValid <= 1'b0;
        end else begin
            pending     <= mv.reqValid && mv.reqReady;
            mv.rspValid <= pending;
        end
    end

    always_ff @(posedge Clk) begin
        if (mv.reqValid && mv.reqReady) begin
            holdDir   <= mv.dir;
            holdBoard <= mv.board;
        end
        if (pending) begin
            mv.rspBoard <= shifted;
        end
    end

    assert property (@(posedge Clk) disable iff (Reset)
        mv.rspValid |=> !mv.rspValid);

endmodule

// File: game/game_control.sv
`timescale 1ns/1ps
`include "game_config.svh"

module game_control (
    input  logic             Clk,
    input  logic             Reset,
    input  logic             moveValid,
    input  game_pkg::dir_t   moveDir,
    output logic             moveReady,
    moveIf.ctrl              mv,
    output game_pkg::board_t board,
    output logic             gameWon,
    output logic             gameLost
);
    import game_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DONE
    } state_t;

    state_t state;
    board_t spawnBoard;
    logic   hasEmpty;
    logic   hasWin;

    assign moveReady = (state == ST_IDLE);
    // board is held steady for the whole request
    assign mv.board  = board;

    // new tile goes in the first empty cell, row-major
    always_comb begin
        spawnBoard = mv.rspBoard;
        hasEmpty   = 1'b0;
        for (int r = 0; r < `GAME_DIM; r++) begin
            for (int c = 0; c < `GAME_DIM; c++) begin
                if (mv.rspBoard[r][c] == '0 && !hasEmpty) begin
                    spawnBoard[r][c] = TILE_NEW;
                    hasEmpty         = 1'b1;
                end
            end
        end
        hasWin = 1'b0;
        for (int r = 0; r < `GAME_DIM; r++) begin
            for (int c = 0; c < `GAME_DIM; c++) begin
                if (spawnBoard[r][c] == tile_t'(`GAME_WIN_EXP)) begin
                    hasWin = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            state       <= ST_IDLE;
            mv.reqValid <= 1'b0;
            board       <= BOARD_INIT;
            gameWon     <= 1'b0;
            gameLost    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (moveValid) begin
                        state       <= ST_WAIT;
                        mv.reqValid <= 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (mv.reqValid && mv.reqReady) begin
                        mv.reqValid <= 1'b0;
                    end
                    if (mv.rspValid) begin
                        board    <= spawnBoard;
                        gameWon  <= hasWin;
                        gameLost <= !hasWin && !hasEmpty;
                        state    <= (hasWin || !hasEmpty) ? ST_DONE : ST_IDLE;
                    end
                end
                // win or loss, held until reset
                default: state <= ST_DONE;
            endcase
        end
    end

    // direction latched at acceptance, host may drop moveDir afterwards
    always_ff @(posedge Clk) begin
        if (moveReady && moveValid) begin
            mv.dir <= moveDir;
        end
    end

    // no new move while the shifter still owns one
    assert property (@(posedge Clk) disable iff (Reset)
        (mv.reqValid || mv.rspValid) |-> !moveReady);

    assert property (@(posedge Clk) disable iff (Reset)
        !(gameWon && gameLost));

endmodule

// File: display/tile_renderer.sv
`timescale 1ns/1ps
`include "game_config.svh"

module tile_renderer (
    input  video_pkg::coord_t hCount,
    input  video_pkg::coord_t vCount,
    input  logic              bright,
    input  game_pkg::board_t  board,
    output video_pkg::rgb_t   rgb
);
    import game_pkg::*;
    import video_pkg::*;

    localparam int IdxW = $clog2(`GAME_DIM);

    logic [IdxW:0] colHit;
    logic [IdxW:0] rowHit;

    // {inside, index} along one axis
    function automatic logic [IdxW:0] findCell(coord_t pos, coord_t origin);
        coord_t        off;
        logic [IdxW:0] result;
        off    = pos - origin;
        result = '0;
        if (pos >= origin) begin
            for (int i = 0; i < `GAME_DIM; i++) begin
                if (off >= coord_t'(i * `CELL_PITCH) &&
                    off < coord_t'(i * `CELL_PITCH + `CELL_SIZE)) begin
                    result = {1'b1, IdxW'(i)};
                end
            end
        end
        return result;
    endfunction

    function automatic rgb_t tileColor(tile_t e);
        case (e)
            4'd0:    return `COLOR_EMPTY;
            4'd1:    return `COLOR_TILE1;
            4'd2:    return `COLOR_TILE2;
            4'd3:    return `COLOR_TILE3;
            4'd4:    return `COLOR_TILE4;
            4'd5:    return `COLOR_TILE5;
            4'd6:    return `COLOR_TILE6;
            4'd7:    return `COLOR_TILE7;
            4'd8:    return `COLOR_TILE8;
            4'd9:    return `COLOR_TILE9;
            4'd10:   return `COLOR_TILE10;
            default: return `COLOR_TILE11;
        endcase
    endfunction

    assign colHit = findCell(hCount, coord_t'(`CELL_X0));
    assign rowHit = findCell(vCount, coord_t'(`CELL_Y0));

    always_comb begin
        if (!bright) begin
            rgb = `COLOR_BLANK;
        end else if (colHit[IdxW] && rowHit[IdxW]) begin
            rgb = tileColor(board[rowHit[IdxW-1:0]][colHit[IdxW-1:0]]);
        end else begin
            rgb = `COLOR_BG;
        end
    end

endmodule

// File: design/game_top.sv
`timescale 1ns/1ps

module game_top (
    input  logic              Clk,
    input  logic              Reset,
    input  logic              moveValid,
    input  game_pkg::dir_t    moveDir,
    output logic              moveReady,
    input  video_pkg::coord_t hCount,
    input  video_pkg::coord_t vCount,
    input  logic              bright,
    output video_pkg::rgb_t   rgb,
    output logic              gameWon,
    output logic              gameLost
);
    import game_pkg::*;

    board_t boardState;

    moveIf mvBus ();

    game_control ctrl0 (
        .Clk       (Clk),
        .Reset     (Reset),
        .moveValid (moveValid),
        .moveDir   (moveDir),
        .moveReady (moveReady),
        .mv        (mvBus.ctrl),
        .board     (boardState),
        .gameWon   (gameWon),
        .gameLost  (gameLost)
    );

    board_shifter shift0 (
        .Clk   (Clk),
        .Reset (Reset),
        .mv    (mvBus.shift)
    );

    // display reads the live board
    tile_renderer render0 (
        .hCount (hCount),
        .vCount (vCount),
        .bright (bright),
        .board  (boardState),
        .rgb    (rgb)
    );

endmodule

// File: tb/game_tb.sv
`timescale 1ns/1ps
`include "game_config.svh"

module game_tb;
    import game_pkg::*;
    import video_pkg::*;

    localparam int DirectedMoves = 4 * 6;
    localparam int RandomMoves   = 300;
    localparam int MaxTermMoves  = 3000;
    localparam int CyclesPerMove = 40;
    localparam int ReadyTimeout  = 8;
    localparam int WatchdogNs    =
        (DirectedMoves + RandomMoves + MaxTermMoves + 20) * CyclesPerMove * 20 + 20000;

    logic   Clk;
    logic   Reset;
    logic   moveValid;
    dir_t   moveDir;
    logic   moveReady;
    coord_t hCount;
    coord_t vCount;
    logic   bright;
    rgb_t   rgb;
    logic   gameWon;
    logic   gameLost;

    // expected board, row 0 at the top
    int model [0:`GAME_DIM-1][0:`GAME_DIM-1];
    bit modelWon;
    bit modelLost;

    int errors    = 0;
    int checks    = 0;
    int moveCount = 0;
    bit checkReq  = 1'b0;

    game_top dut0 (
        .Clk       (Clk),
        .Reset     (Reset),
        .moveValid (moveValid),
        .moveDir   (moveDir),
        .moveReady (moveReady),
        .hCount    (hCount),
        .vCount    (vCount),
        .bright    (bright),
        .rgb       (rgb),
        .gameWon   (gameWon),
        .gameLost  (gameLost)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    initial begin
        #(WatchdogNs);
        $display("watchdog expired at %0t, the run stalled", $time);
        $display("Test FAILED");
        $finish;
    end

    // cell position of entry p of line l for a move
    function automatic int lineRow(dir_t d, int l, int p);
        case (d)
            DIR_UP:   return p;
            DIR_DOWN: return `GAME_DIM - 1 - p;
            default:  return l;
        endcase
    endfunction

    function automatic int lineCol(dir_t d, int l, int p);
        case (d)
            DIR_LEFT:  return p;
            DIR_RIGHT: return `GAME_DIM - 1 - p;
            default:   return l;
        endcase
    endfunction

    function automatic void resetModel();
        for (int r = 0; r < `GAME_DIM; r++) begin
            for (int c = 0; c < `GAME_DIM; c++) begin
                model[r][c] = 0;
            end
        end
        model[0][0] = 1;
        modelWon    = 1'b0;
        modelLost   = 1'b0;
    endfunction

    // slide, merge each tile once, spawn, then judge win or loss
    function automatic void predictMove(dir_t d);
        int tiles[$];
        int merged[$];
        int next [0:`GAME_DIM-1][0:`GAME_DIM-1];
        int i;
        bit spawned;
        bit won;
        for (int l = 0; l < `GAME_DIM; l++) begin
            tiles.delete();
            merged.delete();
            for (int p = 0; p < `GAME_DIM; p++) begin
                if (model[lineRow(d, l, p)][lineCol(d, l, p)] != 0) begin
                    tiles.push_back(model[lineRow(d, l, p)][lineCol(d, l, p)]);
                end
            end
            i = 0;
            while (i < tiles.size()) begin
                if (i + 1 < tiles.size() && tiles[i] == tiles[i + 1]) begin
                    merged.push_back(tiles[i] + 1);
                    i += 2;
                end else begin
                    merged.push_back(tiles[i]);
                    i += 1;
                end
            end
            for (int p = 0; p < `GAME_DIM; p++) begin
                next[lineRow(d, l, p)][lineCol(d, l, p)] =
                    (p < merged.size()) ? merged[p] : 0;
            end
        end
        spawned = 1'b0;
        won     = 1'b0;
        for (int r = 0; r < `GAME_DIM; r++) begin
            for (int c = 0; c < `GAME_DIM; c++) begin
                if (!spawned && next[r][c] == 0) begin
                    next[r][c] = 1;
                    spawned    = 1'b1;
                end
                if (next[r][c] == `GAME_WIN_EXP) begin
                    won = 1'b1;
                end
            end
        end
        model     = next;
        modelWon  = won;
        modelLost = !won && !spawned;
    endfunction

    // -1 for a colour that no tile uses
    function automatic int colorToExp(rgb_t value);
        case (value)
            `COLOR_EMPTY:  return 0;
            `COLOR_TILE1:  return 1;
            `COLOR_TILE2:  return 2;
            `COLOR_TILE3:  return 3;
            `COLOR_TILE4:  return 4;
            `COLOR_TILE5:  return 5;
            `COLOR_TILE6:  return 6;
            `COLOR_TILE7:  return 7;
            `COLOR_TILE8:  return 8;
            `COLOR_TILE9:  return 9;
            `COLOR_TILE10: return 10;
            `COLOR_TILE11: return 11;
            default:       return -1;
        endcase
    endfunction

    function automatic int cellX(int c);
        return `CELL_X0 + c * `CELL_PITCH + `CELL_SIZE / 2;
    endfunction

    function automatic int cellY(int r);
        return `CELL_Y0 + r * `CELL_PITCH + `CELL_SIZE / 2;
    endfunction

    function automatic dir_t randomDir();
        int r;
        r = int'($urandom_range(3, 0));
        return dir_t'(r[1:0]);
    endfunction

    task automatic checkValue(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            $display("ERROR: time %0t, %s: expected %0d, got %0d",
                     $time, name, expected, got);
            errors++;
        end
    endtask

    task automatic probeRgb(input int x, input int y, input logic on, output int value);
        @(posedge Clk);
        bright <= on;
        hCount <= coord_t'(x);
        vCount <= coord_t'(y);
        @(negedge Clk);
        value = int'(rgb);
    endtask

    task automatic compareBoard();
        int value;
        for (int r = 0; r < `GAME_DIM; r++) begin
            for (int c = 0; c < `GAME_DIM; c++) begin
                probeRgb(cellX(c), cellY(r), 1'b1, value);
                checkValue($sformatf("rgb of cell[%0d][%0d] as exponent", r, c),
                           colorToExp(rgb_t'(value)), model[r][c]);
            end
        end
        @(negedge Clk);
        checkValue("gameWon", int'(gameWon), int'(modelWon));
        checkValue("gameLost", int'(gameLost), int'(modelLost));
    endtask

    // compare process, runs on request after each move
    initial begin
        forever begin
            wait (checkReq);
            compareBoard();
            checkReq = 1'b0;
        end
    end

    task automatic requestCheck();
        checkReq = 1'b1;
        wait (!checkReq);
    endtask

    task automatic sendMove(input dir_t d, input int gap, input int hold);
        int lowCycles;
        bit terminal;
        repeat (gap) @(posedge Clk);
        @(posedge Clk);
        moveValid <= 1'b1;
        moveDir   <= d;
        @(negedge Clk);
        checkValue("moveReady before accept", int'(moveReady), 1);
        // move taken on this edge
        @(posedge Clk);
        predictMove(d);
        moveCount++;
        terminal = modelWon || modelLost;
        if (hold == 0) begin
            moveValid <= 1'b0;
        end
        lowCycles = 0;
        @(negedge Clk);
        while (!moveReady && lowCycles < ReadyTimeout) begin
            lowCycles++;
            @(posedge Clk);
            // request held on while busy
            if (lowCycles >= hold) begin
                moveValid <= 1'b0;
            end
            @(negedge Clk);
        end
        checkValue("moveReady low cycles", lowCycles, terminal ? ReadyTimeout : 3);
        requestCheck();
        @(negedge Clk);
        checkValue("moveReady after move", int'(moveReady), terminal ? 0 : 1);
    endtask

    task automatic pokeWhileDone(input int count);
        for (int k = 0; k < count; k++) begin
            @(posedge Clk);
            moveValid <= 1'b1;
            moveDir   <= randomDir();
            repeat (2) @(posedge Clk);
            moveValid <= 1'b0;
            @(negedge Clk);
            checkValue("moveReady in end state", int'(moveReady), 0);
        end
        requestCheck();
    endtask

    task automatic applyReset();
        @(posedge Clk);
        Reset     <= 1'b1;
        moveValid <= 1'b0;
        repeat (4) @(posedge Clk);
        Reset <= 1'b0;
        resetModel();
    endtask

    task automatic checkResetState();
        int value;
        requestCheck();
        @(negedge Clk);
        checkValue("moveReady", int'(moveReady), 1);
        probeRgb(cellX(0), cellY(0), 1'b0, value);
        checkValue("rgb with bright low", value, int'(`COLOR_BLANK));
        // gap between the first two columns
        probeRgb(`CELL_X0 + `CELL_SIZE + 1, cellY(0), 1'b1, value);
        checkValue("rgb between cells", value, int'(`COLOR_BG));
        probeRgb(10, 10, 1'b1, value);
        checkValue("rgb outside board", value, int'(`COLOR_BG));
    endtask

    task automatic reportTest(input string name, input int errStart);
        $display("%s: %s, %0d new errors", name,
                 (errors == errStart) ? "passed" : "failed", errors - errStart);
    endtask

    initial begin
        int   errStart;
        dir_t primary;
        dir_t d;
        Reset     = 1'b1;
        moveValid = 1'b0;
        moveDir   = DIR_UP;
        hCount    = '0;
        vCount    = '0;
        bright    = 1'b0;
        void'($urandom(29959));
        applyReset();

        errStart = errors;
        checkResetState();
        reportTest("reset state", errStart);

        // short fixed sequences, one cross move to stack up equal tiles
        for (int t = 0; t < 4; t++) begin
            errStart = errors;
            applyReset();
            primary = dir_t'(t[1:0]);
            for (int s = 0; s < 6; s++) begin
                d = primary;
                if (s == 2) begin
                    d = (t < 2) ? DIR_LEFT : DIR_UP;
                end
                sendMove(d, 0, s % 4);
            end
            reportTest($sformatf("directed %s", primary.name()), errStart);
        end

        errStart = errors;
        for (int n = 0; n < RandomMoves && !(modelWon || modelLost); n++) begin
            sendMove(randomDir(), int'($urandom_range(3, 0)), int'($urandom_range(3, 0)));
        end
        reportTest("random moves", errStart);

        errStart = errors;
        for (int n = 0; n < MaxTermMoves && !(modelWon || modelLost); n++) begin
            sendMove(randomDir(), int'($urandom_range(3, 0)), int'($urandom_range(3, 0)));
        end
        if (!(modelWon || modelLost)) begin
            $display("no win or loss was reached within %0d further moves", MaxTermMoves);
            errors++;
        end else begin
            $display("game ended by %s after %0d moves",
                     modelWon ? "a win" : "a loss", moveCount);
            pokeWhileDone(3);
            applyReset();
            checkResetState();
        end
        reportTest("end state and reset", errStart);

        $display("moves %0d, checks %0d, errors %0d", moveCount, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/game_pkg.sv
common/video_pkg.sv
common/move_if.sv
game/line_merge.sv
game/board_shifter.sv
game/game_control.sv
display/tile_renderer.sv
design/game_top.sv
tb/game_tb.sv

// File: run.sh
#!/bin/sh
# build and run the game testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -f verilog.f --top-module game_tb -o game_sim
./obj_dir/game_sim > sim.log 2>&1 || true
cat sim.log
grep -q "^Test OK$" sim.log
